//--- all.f
logic/McbBusPkg.sv
logic/McbCsrPkg.sv
logic/UfiStageIf.sv
logic/MicroControllerCsr.sv
logic/SyncFifoController.sv
logic/GpioUsiBridge.sv
logic/MicroControllerBlock.sv
sim/McbTb.sv

//--- sim/McbTb.sv
`timescale 1ns/1ps

module McbTb;

	localparam logic [7:0] OwnBlock   = 8'h01;
	localparam logic [7:0] OtherBlock = 8'h02;
	localparam int         WaitLimit  = 200;

	logic                iSCLK = 1'b0;
	logic                iSRST;
	McbBusPkg::usiWord_t iSUsiWd;
	McbBusPkg::usiWord_t iSUsiAdrs;
	McbBusPkg::usiWord_t oSUsiRd;
	logic [15:0]         gpioWrMsb;
	logic [15:0]         gpioWrLsb;
	logic [15:0]         gpioDataEn;
	logic [15:0]         gpioAdrsEn;
	logic [15:0]         gpioRdMsb;
	logic [15:0]         gpioRdLsb;
	McbBusPkg::usiWord_t iMUsiRd;
	McbBusPkg::usiWord_t oMUsiWd;
	McbBusPkg::usiWord_t oMUsiAdrs;
	logic [15:0]         oMUfiWd;
	logic [31:0]         oMUfiAdrs;
	logic                oMUfiVld;
	logic                iMUfiRdy;

	// Expected UFI entries, oldest first
	McbBusPkg::ufiEntry_t expQ[$];
	integer               seed;
	int                   pushCount;
	int                   errCnt;
	int                   passCnt;
	int                   failCnt;

	MicroControllerBlock #(
		.pAdrsMap(OwnBlock),
		.pFifoDepth(8)
	) u_MicroControllerBlock (.*);

	always #10 iSCLK = ~iSCLK;

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic compareWord(input McbBusPkg::usiWord_t got, input McbBusPkg::usiWord_t exp,
		input string msg);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
			errCnt++;
		end
	endtask

	task automatic compareEntry(input McbBusPkg::ufiEntry_t got, input McbBusPkg::ufiEntry_t exp,
		input string msg);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got adrs %h wd %h expected adrs %h wd %h",
				$time, msg, got.adrs, got.wd, exp.adrs, exp.wd);
			errCnt++;
		end
	endtask

	task automatic compareHalf(input logic [15:0] got, input logic [15:0] exp, input string msg);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
			errCnt++;
		end
	endtask

	task automatic compareFlag(input logic got, input logic exp, input string msg);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
			errCnt++;
		end
	endtask

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic McbBusPkg::usiWord_t csrAdrs(input logic [7:0] blk, input logic [7:0] ofs);
		return {blk, 16'h0000, ofs};
	endfunction

	// Pending in bit 0, full in bit 1, count in bits 15 to 8
	function automatic McbBusPkg::usiWord_t makeStatus(input logic pend, input logic full,
		input int cnt);
		return {16'h0000, cnt[7:0], 6'b000000, full, pend};
	endfunction

	function automatic McbBusPkg::ufiEntry_t randomEntry();
		McbBusPkg::ufiEntry_t ent;
		McbBusPkg::usiWord_t  rnd;
		ent.adrs = $random(seed);
		rnd      = $random(seed);
		ent.wd   = rnd[15:0];
		return ent;
	endfunction

	// Address is nonzero for the write cycle only
	task automatic csrWrite(input McbBusPkg::usiWord_t adrs, input McbBusPkg::usiWord_t data);
		@(posedge iSCLK);
		iSUsiAdrs <= adrs;
		iSUsiWd   <= data;
		@(posedge iSCLK);
		iSUsiAdrs <= '0;
	endtask

	task automatic pushEntry(input McbBusPkg::ufiEntry_t ent);
		csrWrite(csrAdrs(OwnBlock, McbCsrPkg::CsrOfsWd), {16'h0000, ent.wd});
		csrWrite(csrAdrs(OwnBlock, McbCsrPkg::CsrOfsAdrs), ent.adrs);
		expQ.push_back(ent);
		pushCount++;
		csrWrite(csrAdrs(OwnBlock, McbCsrPkg::CsrOfsCmd), {30'h0, McbCsrPkg::CmdPush});
	endtask

	task automatic setReady(input logic rdy);
		@(posedge iSCLK);
		iMUfiRdy <= rdy;
	endtask

	task automatic waitStatus(input McbBusPkg::usiWord_t mask, input McbBusPkg::usiWord_t want,
		input string what);
		int cycles;
		cycles = 0;
		@(negedge iSCLK);
		while (((oSUsiRd & mask) !== want) && (cycles < WaitLimit))
		begin
			@(negedge iSCLK);
			cycles++;
		end
		if ((oSUsiRd & mask) !== want)
		begin
			$display("Timed out at %0t waiting for status word: %s", $time, what);
			errCnt++;
		end
	endtask

	task automatic waitVld(input logic want, input string what);
		int cycles;
		cycles = 0;
		@(negedge iSCLK);
		while ((oMUfiVld !== want) && (cycles < WaitLimit))
		begin
			@(negedge iSCLK);
			cycles++;
		end
		if (oMUfiVld !== want)
		begin
			$display("Timed out at %0t waiting for oMUfiVld: %s", $time, what);
			errCnt++;
		end
	endtask

	task automatic waitDrained(input string what);
		int cycles;
		cycles = 0;
		@(negedge iSCLK);
		while ((expQ.size() != 0 || oMUfiVld !== 1'b0) && (cycles < WaitLimit))
		begin
			@(negedge iSCLK);
			cycles++;
		end
		if (expQ.size() != 0 || oMUfiVld !== 1'b0)
		begin
			$display("Timed out at %0t: %0d entries never drained in %s", $time, expQ.size(), what);
			errCnt++;
		end
	endtask

	task automatic reportTest(input string name, input int errStart);
		if (errCnt == errStart)
		begin
			passCnt++;
			$display("Test %s passed at %0t", name, $time);
		end
		else
		begin
			failCnt++;
			$display("Test %s failed with %0d errors", name, errCnt - errStart);
		end
	endtask

	// Every accepted UFI beat is checked against the head of the model
	always @(negedge iSCLK)
	begin
		if (!iSRST && oMUfiVld === 1'b1 && iMUfiRdy === 1'b1)
		begin
			if (expQ.size() == 0)
			begin
				$display("Unexpected UFI entry at %0t with none outstanding", $time);
				errCnt++;
			end
			else
				compareEntry({oMUfiAdrs, oMUfiWd}, expQ.pop_front(), "UFI head");
		end
	end

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic testReset();
		int errStart;
		errStart = errCnt;
		@(negedge iSCLK);
		compareFlag(oMUfiVld, 1'b0, "oMUfiVld after reset");
		compareWord(oMUsiAdrs, '0, "oMUsiAdrs after reset");
		compareWord(oMUsiWd, '0, "oMUsiWd after reset");
		compareWord(oSUsiRd, '0, "status after reset");
		reportTest("reset state", errStart);
	endtask

	task automatic testPushDrain();
		int errStart;
		errStart = errCnt;
		setReady(1'b1);
		repeat (5) pushEntry(randomEntry());
		waitDrained("push and drain");
		waitStatus('1, makeStatus(1'b0, 1'b0, pushCount), "count of five");
		reportTest("push and drain", errStart);
	endtask

	task automatic testBackPressure();
		int errStart;
		errStart = errCnt;
		setReady(1'b0);
		repeat (8) pushEntry(randomEntry());
		waitStatus('1, makeStatus(1'b0, 1'b1, pushCount), "FIFO full");
		// Ninth push has no room and waits
		pushEntry(randomEntry());
		waitStatus('1, makeStatus(1'b1, 1'b1, pushCount - 1), "push pending");
		setReady(1'b1);
		waitStatus(32'h1, 32'h0, "pending bit to clear");
		waitDrained("back-pressure");
		waitStatus('1, makeStatus(1'b0, 1'b0, pushCount), "status after drain");
		reportTest("back-pressure", errStart);
	endtask

	task automatic testForeignBlock();
		McbBusPkg::ufiEntry_t ent;
		int                   errStart;
		errStart = errCnt;
		ent = randomEntry();
		// UFI side held off so a stray entry would stay visible
		setReady(1'b0);
		csrWrite(csrAdrs(OwnBlock, McbCsrPkg::CsrOfsWd), {16'h0000, ent.wd});
		csrWrite(csrAdrs(OwnBlock, McbCsrPkg::CsrOfsAdrs), ent.adrs);
		// Same offsets under another block id
		csrWrite(csrAdrs(OtherBlock, McbCsrPkg::CsrOfsWd), $random(seed));
		csrWrite(csrAdrs(OtherBlock, McbCsrPkg::CsrOfsAdrs), $random(seed));
		csrWrite(csrAdrs(OtherBlock, McbCsrPkg::CsrOfsCmd), {30'h0, McbCsrPkg::CmdPush});
		repeat (4) @(posedge iSCLK);
		@(negedge iSCLK);
		compareFlag(oMUfiVld, 1'b0, "oMUfiVld after foreign writes");
		compareWord(oSUsiRd, makeStatus(1'b0, 1'b0, pushCount), "status after foreign writes");
		setReady(1'b1);
		// Staged values must still be the own block's
		expQ.push_back(ent);
		pushCount++;
		csrWrite(csrAdrs(OwnBlock, McbCsrPkg::CsrOfsCmd), {30'h0, McbCsrPkg::CmdPush});
		waitDrained("foreign block");
		waitStatus('1, makeStatus(1'b0, 1'b0, pushCount), "status after own push");
		reportTest("foreign block id", errStart);
	endtask

	task automatic testFlush();
		int errStart;
		errStart = errCnt;
		setReady(1'b0);
		repeat (3) pushEntry(randomEntry());
		waitVld(1'b1, "entries before flush");
		csrWrite(csrAdrs(OwnBlock, McbCsrPkg::CsrOfsCmd), {30'h0, McbCsrPkg::CmdFlush});
		waitVld(1'b0, "flush to empty the FIFO");
		expQ.delete();
		setReady(1'b1);
		repeat (2) pushEntry(randomEntry());
		waitDrained("flush");
		waitStatus('1, makeStatus(1'b0, 1'b0, pushCount), "status after flush");
		reportTest("flush", errStart);
	endtask

	task automatic testGpio();
		McbBusPkg::usiWord_t dataWord;
		McbBusPkg::usiWord_t adrsWord;
		McbBusPkg::usiWord_t rdWord;
		int                  errStart;
		errStart = errCnt;
		dataWord = $random(seed);
		adrsWord = $random(seed) | 32'h1;
		rdWord   = $random(seed);
		@(posedge iSCLK);
		gpioWrMsb  <= dataWord[31:16];
		gpioWrLsb  <= dataWord[15:0];
		gpioDataEn <= 16'h0001;
		@(posedge iSCLK);
		gpioDataEn <= 16'h0000;
		gpioWrMsb  <= adrsWord[31:16];
		gpioWrLsb  <= adrsWord[15:0];
		gpioAdrsEn <= 16'h0001;
		iMUsiRd    <= rdWord;
		@(negedge iSCLK);
		compareWord(oMUsiWd, dataWord, "oMUsiWd after load");
		compareWord(oMUsiAdrs, '0, "oMUsiAdrs before pulse");
		@(posedge iSCLK);
		gpioAdrsEn <= 16'h0000;
		@(negedge iSCLK);
		compareWord(oMUsiAdrs, adrsWord, "oMUsiAdrs pulse");
		compareWord(oMUsiWd, dataWord, "oMUsiWd held");
		compareHalf(gpioRdMsb, rdWord[31:16], "gpioRdMsb");
		compareHalf(gpioRdLsb, rdWord[15:0], "gpioRdLsb");
		@(negedge iSCLK);
		compareWord(oMUsiAdrs, '0, "oMUsiAdrs after pulse");
		compareWord(oMUsiWd, dataWord, "oMUsiWd still held");
		reportTest("GPIO bridge", errStart);
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		seed       = 32'h8fb21c90;
		pushCount  = 0;
		errCnt     = 0;
		passCnt    = 0;
		failCnt    = 0;
		iSRST      = 1'b1;
		iSUsiWd    = '0;
		iSUsiAdrs  = '0;
		gpioWrMsb  = '0;
		gpioWrLsb  = '0;
		gpioDataEn = '0;
		gpioAdrsEn = '0;
		iMUsiRd    = '0;
		iMUfiRdy   = 1'b0;
		repeat (16) @(posedge iSCLK);
		iSRST <= 1'b0;
		testReset();
		testPushDrain();
		testBackPressure();
		testForeignBlock();
		testFlush();
		testGpio();
		$display("Tests passed %0d failed %0d", passCnt, failCnt);
		if (errCnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- logic/MicroControllerBlock.sv
`timescale 1ns/1ps

module MicroControllerBlock #(
	parameter logic [McbCsrPkg::CsrBlockWidth-1:0] pAdrsMap = 8'h01,
	parameter int pFifoDepth = 512
)(
	input  logic                                 iSCLK,
	input  logic                                 iSRST,
	// CSR slave access
	input  McbBusPkg::usiWord_t                  iSUsiWd,
	input  McbBusPkg::usiWord_t                  iSUsiAdrs,
	output McbBusPkg::usiWord_t                  oSUsiRd,
	// CPU GPIO
	input  logic [15:0]                          gpioWrMsb,
	input  logic [15:0]                          gpioWrLsb,
	input  logic [15:0]                          gpioDataEn,
	input  logic [15:0]                          gpioAdrsEn,
	output logic [15:0]                          gpioRdMsb,
	output logic [15:0]                          gpioRdLsb,
	// USI master
	input  McbBusPkg::usiWord_t                  iMUsiRd,
	output McbBusPkg::usiWord_t                  oMUsiWd,
	output McbBusPkg::usiWord_t                  oMUsiAdrs,
	// UFI master write
	output logic [McbBusPkg::UfiDqWidth-1:0]     oMUfiWd,
	output logic [McbBusPkg::UfiAdrsWidth-1:0]   oMUfiAdrs,
	output logic                                 oMUfiVld,
	input  logic                                 iMUfiRdy
);

	UfiStageIf stageIf ();

	McbBusPkg::ufiEntry_t fifoHead;

	// ------------------------------
	// CSR and FIFO
	// ------------------------------
	MicroControllerCsr #(
		.pAdrsMap(pAdrsMap)
	) u_MicroControllerCsr (
		.iSCLK(iSCLK),
		.iSRST(iSRST),
		.iSUsiWd(iSUsiWd),
		.iSUsiAdrs(iSUsiAdrs),
		.oSUsiRd(oSUsiRd),
		.stage(stageIf.csr)
	);

	// Drains whenever the UFI side is ready
	SyncFifoController #(
		.pFifoDepth(pFifoDepth)
	) u_SyncFifoController (
		.iSCLK(iSCLK),
		.iSRST(iSRST),
		.stage(stageIf.fifo),
		.oRd(fifoHead),
		.oVld(oMUfiVld),
		.iRe(iMUfiRdy)
	);

	assign oMUfiAdrs = fifoHead.adrs;
	assign oMUfiWd   = fifoHead.wd;

	// CPU GPIO to USI master
	GpioUsiBridge u_GpioUsiBridge (
		.iSCLK(iSCLK),
		.iSRST(iSRST),
		.gpioWrMsb(gpioWrMsb),
		.gpioWrLsb(gpioWrLsb),
		.gpioDataEn(gpioDataEn),
		.gpioAdrsEn(gpioAdrsEn),
		.gpioRdMsb(gpioRdMsb),
		.gpioRdLsb(gpioRdLsb),
		.iMUsiRd(iMUsiRd),
		.oMUsiWd(oMUsiWd),
		.oMUsiAdrs(oMUsiAdrs)
	);

endmodule

//--- logic/GpioUsiBridge.sv
`timescale 1ns/1ps

module GpioUsiBridge (
	input  logic                iSCLK,
	input  logic                iSRST,
	input  logic [15:0]         gpioWrMsb,
	input  logic [15:0]         gpioWrLsb,
	input  logic [15:0]         gpioDataEn,
	input  logic [15:0]         gpioAdrsEn,
	output logic [15:0]         gpioRdMsb,
	output logic [15:0]         gpioRdLsb,
	input  McbBusPkg::usiWord_t iMUsiRd,
	output McbBusPkg::usiWord_t oMUsiWd,
	output McbBusPkg::usiWord_t oMUsiAdrs
);

	logic adrsEnDly;
	logic adrsPulse;

	// Pulse only on the rising edge of the enable
	assign adrsPulse = gpioAdrsEn[0] && !adrsEnDly;

	// ------------------------------
	// USI master write side
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oMUsiWd   <= '0;
			oMUsiAdrs <= '0;
			adrsEnDly <= 1'b0;
		end
		else
		begin
			adrsEnDly <= gpioAdrsEn[0];
			// Data is held until the next load
			if (gpioDataEn[0])
				oMUsiWd <= {gpioWrMsb, gpioWrLsb};
			// Address lives for one cycle only
			if (adrsPulse)
				oMUsiAdrs <= {gpioWrMsb, gpioWrLsb};
			else
				oMUsiAdrs <= '0;
		end
	end

	// Read word back to the CPU in two halves
	assign gpioRdMsb = iMUsiRd[31:16];
	assign gpioRdLsb = iMUsiRd[15:0];

	adrsOneCycle : assert property (@(posedge iSCLK) disable iff (iSRST)
		(oMUsiAdrs != '0) |=> (oMUsiAdrs == '0))
		else $error("USI address held longer than one cycle");

endmodule

//--- logic/SyncFifoController.sv
`timescale 1ns/1ps

module SyncFifoController #(
	parameter int pFifoDepth = 512
)(
	input  logic                 iSCLK,
	input  logic                 iSRST,
	UfiStageIf.fifo              stage,
	output McbBusPkg::ufiEntry_t oRd,
	output logic                 oVld,
	input  logic                 iRe
);

	localparam int lpAdrsWidth = $clog2(pFifoDepth);

	logic [McbBusPkg::EntryWidth-1:0] fifoMem [pFifoDepth];

	// One extra pointer bit tells full from empty
	logic [lpAdrsWidth:0] wrPtr;
	logic [lpAdrsWidth:0] rdPtr;
	logic [lpAdrsWidth:0] ptrDiff;
	logic                 wrEn;
	logic                 rdEn;
	logic                 empty;

	// ------------------------------
	// Flags
	// ------------------------------
	assign empty      = (wrPtr == rdPtr);
	assign stage.full = (wrPtr[lpAdrsWidth] != rdPtr[lpAdrsWidth]) &&
		(wrPtr[lpAdrsWidth-1:0] == rdPtr[lpAdrsWidth-1:0]);
	assign oVld       = !empty;
	assign ptrDiff    = wrPtr - rdPtr;

	// Flush wins over both write and read
	assign wrEn = stage.we && !stage.flush;
	assign rdEn = iRe && oVld && !stage.flush;

	// Head entry falls through to the output
	assign oRd = McbBusPkg::ufiEntry_t'(fifoMem[rdPtr[lpAdrsWidth-1:0]]);

	// ------------------------------
	// Storage and pointers
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (wrEn)
			fifoMem[wrPtr[lpAdrsWidth-1:0]] <= stage.entry;
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST || stage.flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	noWriteFull : assert property (@(posedge iSCLK) disable iff (iSRST)
		wrEn |-> !stage.full)
		else $error("FIFO written while full");

	// Occupancy bound over time, so no pointer ever laps the other
	ptrSpan : assert property (@(posedge iSCLK) disable iff (iSRST)
		ptrDiff <= pFifoDepth)
		else $error("FIFO pointers %0d apart", ptrDiff);

endmodule

//--- logic/MicroControllerCsr.sv
`timescale 1ns/1ps

module MicroControllerCsr #(
	parameter logic [McbCsrPkg::CsrBlockWidth-1:0] pAdrsMap = 8'h01
)(
	input  logic                iSCLK,
	input  logic                iSRST,
	input  McbBusPkg::usiWord_t iSUsiWd,
	input  McbBusPkg::usiWord_t iSUsiAdrs,
	output McbBusPkg::usiWord_t oSUsiRd,
	UfiStageIf.csr              stage
);

	// ------------------------------
	// Write decode
	// ------------------------------
	logic                              blockHit;
	logic [McbCsrPkg::CsrOfsWidth-1:0] csrOfs;
	McbCsrPkg::csrCmd_t                cmd;
	logic                              pushCmd;
	logic                              flushCmd;

	// Address is only nonzero during a write cycle
	assign blockHit = (iSUsiAdrs != '0) &&
		(iSUsiAdrs[McbCsrPkg::CsrBlockLsb +: McbCsrPkg::CsrBlockWidth] == pAdrsMap);
	assign csrOfs   = iSUsiAdrs[McbCsrPkg::CsrOfsWidth-1:0];
	assign cmd      = McbCsrPkg::csrCmd_t'(iSUsiWd[McbCsrPkg::CmdWidth-1:0]);
	assign pushCmd  = blockHit && (csrOfs == McbCsrPkg::CsrOfsCmd) && (cmd == McbCsrPkg::CmdPush);
	assign flushCmd = blockHit && (csrOfs == McbCsrPkg::CsrOfsCmd) && (cmd == McbCsrPkg::CmdFlush);

	// Staged data and address
	logic [McbBusPkg::UfiDqWidth-1:0]   stagedWd;
	logic [McbBusPkg::UfiAdrsWidth-1:0] stagedAdrs;
	McbBusPkg::ufiEntry_t               entryReg;
	McbCsrPkg::csrState_t               state;

	always_ff @(posedge iSCLK)
	begin
		if (blockHit && csrOfs == McbCsrPkg::CsrOfsWd)
			stagedWd <= iSUsiWd[McbBusPkg::UfiDqWidth-1:0];
		if (blockHit && csrOfs == McbCsrPkg::CsrOfsAdrs)
			stagedAdrs <= iSUsiWd[McbBusPkg::UfiAdrsWidth-1:0];
		// Entry is frozen when the push is taken, pending or not
		if (pushCmd && state == McbCsrPkg::StIdle)
			entryReg <= {stagedAdrs, stagedWd};
	end

	// ------------------------------
	// Push sequencer
	// ------------------------------
	logic                               weReg;
	logic                               flushReg;
	logic [McbCsrPkg::StCntWidth-1:0]   pushCnt;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state    <= McbCsrPkg::StIdle;
			weReg    <= 1'b0;
			flushReg <= 1'b0;
			pushCnt  <= '0;
		end
		else
		begin
			weReg    <= 1'b0;
			flushReg <= 1'b0;
			if (weReg)
				pushCnt <= pushCnt + 1'b1;
			// Flush also drops a pending push
			if (flushCmd)
			begin
				flushReg <= 1'b1;
				state    <= McbCsrPkg::StIdle;
			end
			else
			begin
				case (state)
					McbCsrPkg::StIdle:
						if (pushCmd)
						begin
							// Full only rises through a write, so a free slot now stays free
							if (!stage.full && !weReg)
								weReg <= 1'b1;
							else
								state <= McbCsrPkg::StPushWait;
						end
					McbCsrPkg::StPushWait:
						if (!stage.full)
						begin
							weReg <= 1'b1;
							state <= McbCsrPkg::StIdle;
						end
					default:
						state <= McbCsrPkg::StIdle;
				endcase
			end
		end
	end

	assign stage.entry = entryReg;
	assign stage.we    = weReg;
	assign stage.flush = flushReg;

	// ------------------------------
	// Status readback
	// ------------------------------
	McbBusPkg::usiWord_t statusWord;

	always_comb
	begin
		statusWord = '0;
		statusWord[McbCsrPkg::StPendBit] = (state == McbCsrPkg::StPushWait);
		statusWord[McbCsrPkg::StFullBit] = stage.full;
		statusWord[McbCsrPkg::StCntLsb +: McbCsrPkg::StCntWidth] = pushCnt;
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oSUsiRd <= '0;
		else
			oSUsiRd <= statusWord;
	end

	// FIFO never sees a write it cannot take
	weNotFull : assert property (@(posedge iSCLK) disable iff (iSRST)
		stage.we |-> !stage.full)
		else $error("stage write while FIFO full");

	weFlushExcl : assert property (@(posedge iSCLK) disable iff (iSRST)
		!(stage.we && stage.flush))
		else $error("stage write and flush in one cycle");

endmodule

//--- logic/UfiStageIf.sv
`timescale 1ns/1ps

// Staged entries travelling from the CSR block into the FIFO
interface UfiStageIf;

	McbBusPkg::ufiEntry_t entry;
	logic                 we;
	logic                 flush;
	logic                 full;

	modport csr
	(
		output entry,
		output we,
		output flush,
		input  full
	);

	modport fifo
	(
		input  entry,
		input  we,
		input  flush,
		output full
	);

endinterface

//--- logic/McbCsrPkg.sv
package McbCsrPkg;

	// Block select field of a USI address, bits 31 to 24
	localparam int CsrBlockLsb   = 24;
	localparam int CsrBlockWidth = 8;

	// Register offsets in the low byte
	localparam int CsrOfsWidth = 8;
	localparam logic [CsrOfsWidth-1:0] CsrOfsWd   = 8'h04;
	localparam logic [CsrOfsWidth-1:0] CsrOfsAdrs = 8'h08;
	localparam logic [CsrOfsWidth-1:0] CsrOfsCmd  = 8'h0C;

	// Command code sits in the low bits of the write data
	localparam int CmdWidth = 2;

	typedef enum logic [CmdWidth-1:0]
	{
		CmdNop   = 2'd0,
		CmdPush  = 2'd1,
		CmdFlush = 2'd2
	} csrCmd_t;

	typedef enum logic
	{
		StIdle     = 1'b0,
		StPushWait = 1'b1
	} csrState_t;

	// Status word layout
	localparam int StPendBit  = 0;
	localparam int StFullBit  = 1;
	localparam int StCntLsb   = 8;
	localparam int StCntWidth = 8;

endpackage

//--- logic/McbBusPkg.sv
package McbBusPkg;

	// ------------------------------
	// USI bus
	// ------------------------------

	// Data and address share one width
	localparam int UsiWidth = 32;

	typedef logic [UsiWidth-1:0] usiWord_t;

	// ------------------------------
	// UFI bus and FIFO entry
	// ------------------------------
	localparam int UfiDqWidth   = 16;
	localparam int UfiAdrsWidth = 32;

	// Address in the upper bits, data in the lower bits
	localparam int EntryWidth = UfiAdrsWidth + UfiDqWidth;

	typedef struct packed
	{
		logic [UfiAdrsWidth-1:0] adrs;
		logic [UfiDqWidth-1:0]   wd;
	} ufiEntry_t;

endpackage
